//--- Makefile
# Verilator build and run of the divider core testbench

VERILATOR ?= verilator
TOP       ?= divUnitTb
FILELIST  ?= fpDiv.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q -F -- "$(PASS_MSG)" $(LOG) && echo "test passed" || \
		(echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- fpDiv.f
hdl/divPkg.sv
hdl/divCtrl.sv
hdl/divIterStage.sv
hdl/divDatapath.sv
hdl/divUnit.sv
tb/divUnitTb.sv

//--- hdl/divCtrl.sv
/*
  Sequencer of the divider core. A start is only taken in Idle.
  Load follows start by one cycle, then MantW/DigitsPerCycle Iterate cycles.
  DigitsPerCycle has to divide MantW.
*/

module divCtrl #(
  parameter int unsigned DigitsPerCycle = 4
) (
  input  logic Clk_CI,
  input  logic Rst_RBI,
  input  logic start,
  output logic load,
  output logic iterEn,
  output logic lastStep,
  output logic ready,
  output logic done
);

  localparam int unsigned NSteps = divPkg::MantW / DigitsPerCycle;
  localparam divPkg::stepCntT LastCnt = divPkg::stepCntT'(NSteps - 1);

  divPkg::divStateT state;
  divPkg::divStateT stateNext;
  divPkg::stepCntT  stepCnt;

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    stateNext = state;
    case (state)
      divPkg::Idle:
      begin
        if (start)
          stateNext = divPkg::Load;  // Load acts as the delayed start
      end
      divPkg::Load:
        stateNext = divPkg::Iterate;
      divPkg::Iterate:
      begin
        if (stepCnt == LastCnt)
          stateNext = divPkg::Idle;
      end
      default:
        stateNext = divPkg::Idle;
    endcase
  end

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      state   <= divPkg::Idle;
      stepCnt <= '0;
    end
    else
    begin
      state <= stateNext;
      if (state == divPkg::Iterate)
        stepCnt <= stepCnt + 1'b1;
      else
        stepCnt <= '0;
    end
  end

  assign load     = (state == divPkg::Load);
  assign iterEn   = load | (state == divPkg::Iterate);
  assign lastStep = (state == divPkg::Iterate) && (stepCnt == LastCnt);

  // handshake strobes
  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      ready <= 1'b1;
      done  <= 1'b0;
    end
    else
    begin
      done <= lastStep;       // result gets latched on the same edge
      if (lastStep)
        ready <= 1'b1;
      else if (load)
        ready <= 1'b0;
    end
  end

endmodule

//--- hdl/divDatapath.sv
/*
  Remainder, quotient and result registers of the divider core.
  num and den must hold from start until done.
  Result mantissa is the floor quotient before normalization.
*/

module divDatapath #(
  parameter int unsigned DigitsPerCycle = 4
) (
  input  logic                      Clk_CI,
  input  logic                      Rst_RBI,
  input  logic                      load,
  input  logic                      iterEn,
  input  logic                      lastStep,
  input  divPkg::divOperandT        num,
  input  divPkg::divOperandT        den,
  input  divPkg::remT               nextRem,
  input  logic [DigitsPerCycle-1:0] qBits,
  input  logic                      corrCarry,
  output divPkg::remT               rem,
  output logic                      lastQBit,
  output divPkg::divResultT         result
);

  divPkg::mantT   quot;
  divPkg::expResT expNext;

  ////////////////////////////////////////////////////////////
  // iteration registers
  ////////////////////////////////////////////////////////////

  // remainder and quotient step on every active cycle
  always_ff @(posedge Clk_CI)
  begin
    if (iterEn)
    begin
      rem  <= nextRem;
      quot <= divPkg::mantT'({quot, qBits});  // new digits enter at the lsb
    end
  end

  assign lastQBit = quot[0];

  ////////////////////////////////////////////////////////////
  // result
  ////////////////////////////////////////////////////////////

  // signed biased difference plus bias
  assign expNext = divPkg::expResT'({2'b00, num.exp})
                 - divPkg::expResT'({2'b00, den.exp})
                 + divPkg::expResT'(divPkg::ExpBias);

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      result <= '0;
    end
    else
    begin
      if (load)
        result.exp <= expNext;
      // quot already holds all digits so the extra digits of this cycle are dropped
      if (lastStep)
        result.mant <= quot + divPkg::mantT'(corrCarry);
    end
  end

endmodule

//--- hdl/divIterStage.sv
/*
  Combinational chain of DigitsPerCycle non-restoring add/subtract cells.
  The first cell in the load cycle computes num - den - 1, so the quotient
  comes out one low in some cases; corrCarry fixes that after the last step.
*/

module divIterStage #(
  parameter int unsigned DigitsPerCycle = 4
) (
  input  logic                      load,
  input  divPkg::mantT              numMant,
  input  divPkg::mantT              denMant,
  input  divPkg::remT               rem,
  input  logic                      lastQBit,
  output divPkg::remT               nextRem,
  output logic [DigitsPerCycle-1:0] qBits,
  output logic                      corrCarry
);

  localparam int unsigned MantW = divPkg::MantW;
  localparam int unsigned CorrW = MantW + 2;

  // weight of the first quotient bit in remainder units
  localparam logic [CorrW-1:0] CorrOffset = {2'b00, 1'b1, {(MantW-1){1'b0}}};

  divPkg::remT denExt;
  divPkg::remT denInv;

  divPkg::remT [DigitsPerCycle-1:0] cellA;
  divPkg::remT [DigitsPerCycle-1:0] cellSum;
  logic [DigitsPerCycle-1:0]        cellSel;    // 1 selects ~den
  logic [DigitsPerCycle-1:0]        cellCarry;

  assign denExt = {1'b0, denMant};
  assign denInv = ~denExt;

  ////////////////////////////////////////////////////////////
  // iteration cells
  ////////////////////////////////////////////////////////////

  // load starts from the numerator with a subtraction
  assign cellA[0]   = load ? {1'b0, numMant} : {rem[MantW-1:0], lastQBit};
  assign cellSel[0] = load | lastQBit;

  for (genvar i = 0; i < DigitsPerCycle; i++)
  begin : genCell
    divPkg::remT opB;

    assign opB = cellSel[i] ? denInv : denExt;
    assign {cellCarry[i], cellSum[i]} = {1'b0, cellA[i]} + {1'b0, opB};
    assign qBits[DigitsPerCycle-1-i] = cellCarry[i];  // first cell is the msb

    if (i < DigitsPerCycle - 1)
    begin : genLink
      // shifted carry in the lsb supplies the +1 of the next subtraction
      assign cellA[i+1]   = {cellSum[i][MantW-1:0], cellCarry[i]};
      assign cellSel[i+1] = cellCarry[i];
    end
  end

  assign nextRem = cellSum[DigitsPerCycle-1];

  ////////////////////////////////////////////////////////////
  // final correction
  ////////////////////////////////////////////////////////////

  // restore the remainder and then test rem + offset >= den
  logic [CorrW-1:0] remSe;
  logic [CorrW-1:0] corrSub;
  logic [CorrW-1:0] corrSum;

  assign remSe     = {rem[MantW], rem};
  assign corrSub   = lastQBit ? {2'b00, denMant} : '0;  // restored negative rem cancels den
  assign corrSum   = remSe + CorrOffset - corrSub;
  assign corrCarry = ~corrSum[CorrW-1];

endmodule

//--- hdl/divPkg.sv
/*
  Shared widths and types of the divider core.
  Mantissas include the hidden bit; exponents are biased by ExpBias.
  The step counter is sized for the one digit per cycle case.
*/

package divPkg;

  ////////////////////////////////////////////////////////////
  // widths and constants
  ////////////////////////////////////////////////////////////

  localparam int unsigned MantW   = 24;  // hidden bit included
  localparam int unsigned ExpW    = 8;
  localparam int unsigned ExpBias = 127;

  // enough for MantW iteration cycles at one digit per cycle
  localparam int unsigned StepCntW = $clog2(MantW);

  ////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////

  typedef logic [MantW-1:0] mantT;              // mantissa or quotient
  typedef logic [MantW:0] remT;                 // partial remainder or cell operand
  typedef logic [ExpW-1:0] expT;                // biased operand exponent
  typedef logic signed [ExpW+1:0] expResT;      // prenorm exponent with room for over/underflow
  typedef logic [StepCntW-1:0] stepCntT;

  typedef struct packed {
    mantT mant;
    expT  exp;
  } divOperandT;

  typedef struct packed {
    mantT   mant;
    expResT exp;
  } divResultT;

  // control FSM
  typedef enum logic [1:0] {
    Idle,
    Load,
    Iterate
  } divStateT;

endpackage

//--- hdl/divUnit.sv
/*
  Mantissa and exponent core of a floating-point divider.
  start is a one-cycle pulse, legal only while ready is high.
  done pulses MantW/DigitsPerCycle + 1 cycles after start is sampled.
*/

module divUnit #(
  parameter int unsigned DigitsPerCycle = 4
) (
  input  logic               Clk_CI,
  input  logic               Rst_RBI,
  input  logic               start,
  input  divPkg::divOperandT num,
  input  divPkg::divOperandT den,
  output logic               ready,
  output logic               done,
  output divPkg::divResultT  result
);

  logic load;
  logic iterEn;
  logic lastStep;
  logic lastQBit;
  logic corrCarry;

  divPkg::remT               rem;
  divPkg::remT               nextRem;
  logic [DigitsPerCycle-1:0] qBits;

  divCtrl #(
    .DigitsPerCycle(DigitsPerCycle)
  ) ctrl_i (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .start   (start),
    .load    (load),
    .iterEn  (iterEn),
    .lastStep(lastStep),
    .ready   (ready),
    .done    (done)
  );

  // one stage reused on every cycle
  divIterStage #(
    .DigitsPerCycle(DigitsPerCycle)
  ) iterStage_i (
    .load     (load),
    .numMant  (num.mant),
    .denMant  (den.mant),
    .rem      (rem),
    .lastQBit (lastQBit),
    .nextRem  (nextRem),
    .qBits    (qBits),
    .corrCarry(corrCarry)
  );

  divDatapath #(
    .DigitsPerCycle(DigitsPerCycle)
  ) datapath_i (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .load     (load),
    .iterEn   (iterEn),
    .lastStep (lastStep),
    .num      (num),
    .den      (den),
    .nextRem  (nextRem),
    .qBits    (qBits),
    .corrCarry(corrCarry),
    .rem      (rem),
    .lastQBit (lastQBit),
    .result   (result)
  );

endmodule

//--- tb/divUnitTb.sv
/*
  Testbench of the divider core at four digits per cycle.
  Directed cases come from tb/divVectors.txt, opened relative to the project root.
  Random cases follow back to back and are checked against a floor-quotient model.
*/

module divUnitTb;

  localparam int unsigned Digits  = 4;
  localparam int unsigned Latency = divPkg::MantW / Digits + 1;  // start edge to done edge
  localparam int unsigned MaxWait = 50;
  localparam int unsigned NRandom = 200;

  logic               Clk_CI;
  logic               Rst_RBI;
  logic               start;
  divPkg::divOperandT num;
  divPkg::divOperandT den;
  logic               ready;
  logic               done;
  divPkg::divResultT  result;

  divPkg::divResultT  lastResult;  // last checked result that must hold until next start
  logic               haveResult;

  divUnit #(
    .DigitsPerCycle(Digits)
  ) dut_i (
    .Clk_CI (Clk_CI),
    .Rst_RBI(Rst_RBI),
    .start  (start),
    .num    (num),
    .den    (den),
    .ready  (ready),
    .done   (done),
    .result (result)
  );

  initial
  begin
    Clk_CI = 1'b0;
    forever
      #10 Clk_CI = ~Clk_CI;
  end

  ////////////////////////////////////////////////////////////
  // checks and reference model
  ////////////////////////////////////////////////////////////

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkMant(input string name, input divPkg::mantT got, input divPkg::mantT want);
    if (got !== want)
      abortRun($sformatf("Error: %s is %h, expected %h", name, got, want));
  endtask

  task automatic checkExp(input string name, input divPkg::expResT got,
                          input divPkg::expResT want);
    if (got !== want)
      abortRun($sformatf("Error: %s is %h, expected %h", name, got, want));
  endtask

  // floor(n * 2^(MantW-1) / d)
  function automatic divPkg::mantT refMant(input divPkg::mantT n, input divPkg::mantT d);
    logic [2*divPkg::MantW-1:0] wide;
    wide = {{divPkg::MantW{1'b0}}, n} << (divPkg::MantW - 1);
    wide = wide / {{divPkg::MantW{1'b0}}, d};
    return divPkg::mantT'(wide);
  endfunction

  function automatic divPkg::expResT refExp(input divPkg::expT n, input divPkg::expT d);
    int e;
    e = int'(n) - int'(d) + int'(divPkg::ExpBias);
    return divPkg::expResT'(e);  // wraps into the 10 bit range
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // inputs change and outputs are settled 2 units after the edge
  task automatic nextCycle();
    @(posedge Clk_CI);
    #2;
  endtask

  task automatic idleCycles(input int unsigned count);
    repeat (count)
    begin
      nextCycle();
      if (done !== 1'b0)
        abortRun("done was high outside its single cycle");
      checkMant("result.mant", result.mant, lastResult.mant);
      checkExp("result.exp", result.exp, lastResult.exp);
    end
  endtask

  task automatic runOp(input divPkg::divOperandT n, input divPkg::divOperandT d,
                       input divPkg::mantT wantMant, input divPkg::expResT wantExp);
    int unsigned waitCnt;
    int unsigned edgeCnt;
    waitCnt = 0;
    while (ready !== 1'b1)
    begin
      nextCycle();
      waitCnt++;
      if (waitCnt > MaxWait)
        abortRun("ready did not return within the timeout");
    end
    num   = n;
    den   = d;
    start = 1'b1;
    nextCycle();  // edge 0
    start = 1'b0;
    if (haveResult)
    begin
      if (done !== 1'b0)
        abortRun("done was high for more than one cycle");
      checkMant("result.mant", result.mant, lastResult.mant);
      checkExp("result.exp", result.exp, lastResult.exp);
    end
    edgeCnt = 0;
    while (done !== 1'b1)
    begin
      nextCycle();
      edgeCnt++;
      if (edgeCnt > MaxWait)
        abortRun("done did not arrive within the timeout");
      if (done !== 1'b1 && ready !== 1'b0)
        abortRun("ready was high while a division was running");
    end
    if (edgeCnt != Latency)
      abortRun($sformatf("done came %0d cycles after start instead of %0d", edgeCnt, Latency));
    if (ready !== 1'b1)
      abortRun("ready did not rise together with done");
    checkMant("result.mant", result.mant, wantMant);
    checkExp("result.exp", result.exp, wantExp);
    lastResult = result;
    haveResult = 1'b1;
  endtask

  initial
  begin
    int                 fd;
    int                 nFields;
    int                 nVectors;
    string              line;
    divPkg::mantT       numMant;
    divPkg::mantT       denMant;
    divPkg::expT        numExp;
    divPkg::expT        denExp;
    divPkg::mantT       wantMant;
    divPkg::expResT     wantExp;
    divPkg::divOperandT n;
    divPkg::divOperandT d;

    void'($urandom(32'h57155e30));
    Rst_RBI    = 1'b0;
    start      = 1'b0;
    num        = '0;
    den        = '0;
    haveResult = 1'b0;
    lastResult = '0;
    repeat (2) @(posedge Clk_CI);
    #2;
    Rst_RBI = 1'b1;

    // quiet after reset
    checkMant("result.mant", result.mant, '0);
    checkExp("result.exp", result.exp, '0);
    repeat (3)
    begin
      if (ready !== 1'b1 || done !== 1'b0)
        abortRun("ready or done had the wrong level after reset");
      nextCycle();
    end

    fd = $fopen("tb/divVectors.txt", "r");
    if (fd == 0)
      abortRun("could not open tb/divVectors.txt");
    nVectors = 0;
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#")
      begin
        nFields = $sscanf(line, "%h %h %h %h %h %h",
                          numMant, numExp, denMant, denExp, wantMant, wantExp);
        if (nFields == 6)
        begin
          n.mant = numMant;
          n.exp  = numExp;
          d.mant = denMant;
          d.exp  = denExp;
          runOp(n, d, wantMant, wantExp);
          idleCycles(3);
          nVectors++;
        end
      end
    end
    $fclose(fd);
    if (nVectors == 0)
      abortRun("the vector file held no usable line");

    // random operands started right when ready returns
    for (int i = 0; i < NRandom; i++)
    begin
      n.mant = divPkg::mantT'($urandom);
      n.mant[divPkg::MantW-1] = 1'b1;  // hidden bit
      n.exp  = divPkg::expT'($urandom);
      d.mant = divPkg::mantT'($urandom);
      d.mant[divPkg::MantW-1] = 1'b1;
      d.exp  = divPkg::expT'($urandom);
      runOp(n, d, refMant(n.mant, d.mant), refExp(n.exp, d.exp));
    end
    idleCycles(2);

    $display("** PASS **");
    $finish;
  end

endmodule

//--- tb/divVectors.txt
# columns, all hex: num.mant num.exp den.mant den.exp result.mant result.exp
# result.exp is 10-bit two's complement, result.mant is floor(num.mant * 2^23 / den.mant)
800000 7f 800000 7f 800000 07f
ffffff 80 800000 7f ffffff 080
800000 01 ffffff fe 400000 382
ffffff fe ffffff 01 800000 17c
c00000 00 800000 ff c00000 380
800000 ff c00000 00 555555 17e
a00000 80 c00000 80 6aaaaa 07f
c00000 7f a00000 80 999999 07e
ffffff 7f 800001 7f fffffd 07f
800001 7f ffffff 7f 400000 07f
800000 7f 800001 7f 7fffff 07f
fffffe 90 ffffff 70 7fffff 09f
b504f3 00 b504f3 00 800000 07f
e00000 85 900000 80 c71c71 084
900000 70 e00000 85 524924 06a
ffffff 01 fffffe 01 800000 07f
